// ==== include/bridge_defines.svh ====
// ======================================================================
// bridge front end constants
// widths, start-up thresholds and dead-time lengths in ADA_DCO cycles
// ======================================================================

`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// tank ADC code width, two's complement
`define ADC_WIDTH 14

// switches of the H-bridge, M1..M4
`define N_SWITCH 4

// start-up counter
`define STARTUP_CNT_WIDTH 8
// last count of bootstrap charging (low sides on)
`define STARTUP_ON_CYCLES 10
// last count of the forced precharge state
`define STARTUP_VG_CYCLES 14

// dead-time counter width
`define DT_CNT_WIDTH 4

// dead-time lengths by select code 00, 10, 01, 11
`define DEADTIME_SEL0 8
`define DEADTIME_SEL1 2
`define DEADTIME_SEL2 4
`define DEADTIME_SEL3 6

`endif

// ==== hw/bridge_pkg.sv ====
// ======================================================================
// bridge front end types
// ======================================================================

`include "bridge_defines.svh"

package bridge_pkg;

   // signed tank ADC code
   typedef logic signed [`ADC_WIDTH-1:0] adc_code_t;

   // one bit per switch
   // bit 0 M1 leg 1 high, bit 1 M2 leg 2 high
   // bit 2 M3 leg 1 low,  bit 3 M4 leg 2 low
   typedef logic [`N_SWITCH-1:0] gate_vec_t;

   typedef logic [1:0] dt_sel_t;
   typedef logic [`DT_CNT_WIDTH-1:0] dt_count_t;
   typedef logic [`STARTUP_CNT_WIDTH-1:0] startup_count_t;

   // converted tank sample, 15 bits
   typedef struct packed {
      adc_code_t value;
      logic      clamped;
   } tank_sample_t;

   // bridge start-up phase
   typedef enum logic [1:0] {PH_OFF, PH_BOOTSTRAP, PH_PRECHARGE, PH_RUN} bridge_phase_t;

endpackage

// ==== hw/tank_adc_capture.sv ====
// ======================================================================
// tank ADC capture
// polarity inversion, over-range clamp, one-entry valid/ready output
// ======================================================================

`timescale 1ns/1ps

`include "bridge_defines.svh"

module tank_adc_capture
   import bridge_pkg::*;
(
   input  logic         ADA_DCO,
   input  logic         i_reset,
   input  adc_code_t    i_adc_data,
   input  logic         i_adc_or,
   output tank_sample_t o_sample,
   output logic         o_sample_valid,
   input  logic         i_sample_ready
);

   // full-scale codes
   localparam adc_code_t CODE_MAX = {1'b0, {(`ADC_WIDTH-1){1'b1}}};
   localparam adc_code_t CODE_MIN = {1'b1, {(`ADC_WIDTH-1){1'b0}}};

   tank_sample_t conv;
   logic         load;

   // ==================================================================
   // conversion
   // ==================================================================
   always_comb begin
      conv.clamped = i_adc_or;
      if (i_adc_or) begin
         // over-range, clamp to full scale of the opposite sign
         conv.value = (i_adc_data == CODE_MIN) ? CODE_MAX : CODE_MIN;
      end else begin
         // sensor polarity is inverted on the board
         // most negative code wraps onto itself
         conv.value = -i_adc_data;
      end
   end

   // ==================================================================
   // output register
   // ==================================================================
   // load when empty or when the held sample leaves this edge
   assign load = !o_sample_valid || i_sample_ready;

   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         o_sample_valid <= 1'b0;
      end else if (load) begin
         // a conversion arrives every edge
         o_sample_valid <= 1'b1;
      end
   end

   // stalled conversions are dropped
   always_ff @(posedge ADA_DCO) begin
      if (load) begin
         o_sample <= conv;
      end
   end

endmodule

// ==== hw/startup_sequencer.sv ====
// ======================================================================
// bootstrap start-up sequencer
// bootstrap charge, forced precharge, then normal switching
// ======================================================================

`timescale 1ns/1ps

`include "bridge_defines.svh"

module startup_sequencer
   import bridge_pkg::*;
(
   input  logic          ADA_DCO,
   input  logic          i_reset,
   input  logic          i_enable,
   output bridge_phase_t o_phase
);

   startup_count_t cnt;

   // counts from enable, stops in run
   // cleared while disabled so each re-enable recharges the bootstrap caps
   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         cnt <= '0;
      end else if (!i_enable) begin
         cnt <= '0;
      end else if (o_phase != PH_RUN) begin
         cnt <= cnt + startup_count_t'(1);
      end
   end

   // ==================================================================
   // phase decode
   // ==================================================================
   always_comb begin
      if (!i_enable) begin
         o_phase = PH_OFF;
      end else if (cnt <= startup_count_t'(`STARTUP_ON_CYCLES)) begin
         // low sides on, bootstrap capacitors charging
         o_phase = PH_BOOTSTRAP;
      end else if (cnt <= startup_count_t'(`STARTUP_VG_CYCLES)) begin
         // force the tank into a known state
         o_phase = PH_PRECHARGE;
      end else begin
         o_phase = PH_RUN;
      end
   end

endmodule

// ==== hw/dead_time_gen.sv ====
// ======================================================================
// dead-time generator
// delays each switch turn-on by a selectable number of cycles
// ======================================================================

`timescale 1ns/1ps

`include "bridge_defines.svh"

module dead_time_gen
   import bridge_pkg::*;
(
   input  logic      ADA_DCO,
   input  logic      i_reset,
   input  gate_vec_t i_cmd,
   input  dt_sel_t   i_dt_sel,
   output gate_vec_t o_cmd
);

   dt_count_t dt_len;

   // select code to dead-time length
   always_comb begin
      case (i_dt_sel)
         2'b00:   dt_len = dt_count_t'(`DEADTIME_SEL0);
         2'b10:   dt_len = dt_count_t'(`DEADTIME_SEL1);
         2'b01:   dt_len = dt_count_t'(`DEADTIME_SEL2);
         default: dt_len = dt_count_t'(`DEADTIME_SEL3);
      endcase
   end

   // ==================================================================
   // per-switch delay
   // ==================================================================
   for (genvar g = 0; g < `N_SWITCH; g++) begin : g_sw
      dt_count_t cnt_q;
      dt_count_t cnt_next;
      logic      out_q;

      // consecutive high edges, saturating
      assign cnt_next = (&cnt_q) ? cnt_q : cnt_q + dt_count_t'(1);

      always_ff @(posedge ADA_DCO) begin
         if (i_reset) begin
            cnt_q <= '0;
            out_q <= 1'b0;
         end else if (!i_cmd[g]) begin
            // turn-off passes straight through
            cnt_q <= '0;
            out_q <= 1'b0;
         end else begin
            cnt_q <= cnt_next;
            // turn-on once the dead time has elapsed, then hold
            if (cnt_next >= dt_len) begin
               out_q <= 1'b1;
            end
         end
      end

      assign o_cmd[g] = out_q;
   end

endmodule

// ==== hw/gate_drive_logic.sv ====
// ======================================================================
// gate combination and shoot-through guard
// ======================================================================

`timescale 1ns/1ps

module gate_drive_logic
   import bridge_pkg::*;
(
   input  logic          ADA_DCO,
   input  logic          i_reset,
   input  logic          i_enable,
   input  bridge_phase_t i_phase,
   input  gate_vec_t     i_dt_cmd,
   output gate_vec_t     o_gate,
   output logic          o_shoot_through
);

   // switch positions in the gate vector
   localparam int M1 = 0;
   localparam int M2 = 1;
   localparam int M3 = 2;
   localparam int M4 = 3;

   // fixed start-up patterns
   // bootstrap M3+M4, precharge M1+M4
   localparam gate_vec_t GATE_BOOT = 4'b1100;
   localparam gate_vec_t GATE_PREC = 4'b1001;

   logic      shorted;
   gate_vec_t pattern;

   // high and low side of the same leg together
   assign shorted = (i_dt_cmd[M1] && i_dt_cmd[M3]) || (i_dt_cmd[M2] && i_dt_cmd[M4]);

   // pattern by phase
   always_comb begin
      case (i_phase)
         PH_BOOTSTRAP: pattern = GATE_BOOT;
         PH_PRECHARGE: pattern = GATE_PREC;
         PH_RUN:       pattern = i_dt_cmd;
         default:      pattern = '0;
      endcase
   end

   // ==================================================================
   // gate register
   // ==================================================================
   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         o_gate          <= '0;
         o_shoot_through <= 1'b0;
      end else begin
         o_shoot_through <= shorted;
         // guard and enable override every phase
         o_gate <= (shorted || !i_enable) ? '0 : pattern;
      end
   end

endmodule

// ==== hw/bridge_ctrl_top.sv ====
// ======================================================================
// H-bridge gate-drive front end
// tank ADC capture, start-up sequencer, dead time and gate guard
// ======================================================================

`timescale 1ns/1ps

module bridge_ctrl_top
   import bridge_pkg::*;
(
   input  logic         ADA_DCO,
   input  logic         i_reset,
   input  logic         i_enable,
   // tank ADC
   input  adc_code_t    i_adc_data,
   input  logic         i_adc_or,
   output tank_sample_t o_sample,
   output logic         o_sample_valid,
   input  logic         i_sample_ready,
   // modulation commands from the controller
   input  gate_vec_t    i_mosfet_cmd,
   input  dt_sel_t      i_deadtime_sel,
   // bridge gates
   output gate_vec_t    o_gate,
   output logic         o_shoot_through
);

   bridge_phase_t phase;
   gate_vec_t     dt_cmd;

   // tank voltage sample stream
   tank_adc_capture u_adc (
      .ADA_DCO        (ADA_DCO),
      .i_reset        (i_reset),
      .i_adc_data     (i_adc_data),
      .i_adc_or       (i_adc_or),
      .o_sample       (o_sample),
      .o_sample_valid (o_sample_valid),
      .i_sample_ready (i_sample_ready)
   );

   startup_sequencer u_startup (
      .ADA_DCO  (ADA_DCO),
      .i_reset  (i_reset),
      .i_enable (i_enable),
      .o_phase  (phase)
   );

   dead_time_gen u_dead_time (
      .ADA_DCO  (ADA_DCO),
      .i_reset  (i_reset),
      .i_cmd    (i_mosfet_cmd),
      .i_dt_sel (i_deadtime_sel),
      .o_cmd    (dt_cmd)
   );

   gate_drive_logic u_gate (
      .ADA_DCO         (ADA_DCO),
      .i_reset         (i_reset),
      .i_enable        (i_enable),
      .i_phase         (phase),
      .i_dt_cmd        (dt_cmd),
      .o_gate          (o_gate),
      .o_shoot_through (o_shoot_through)
   );

endmodule

// ==== sim/tb_bridge_ctrl.sv ====
// ======================================================================
// testbench for the H-bridge gate-drive front end
// directed tests of ADC capture, start-up, dead time and shoot-through
// ======================================================================

`timescale 1ns/1ps

`include "bridge_defines.svh"

module tb_bridge_ctrl
   import bridge_pkg::*;
();

   localparam adc_code_t CODE_MAX = {1'b0, {(`ADC_WIDTH-1){1'b1}}};
   localparam adc_code_t CODE_MIN = {1'b1, {(`ADC_WIDTH-1){1'b0}}};
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
   // reset, adc, back-pressure, start-up, dead time, guard, restart
   localparam int TEST_CYCLES    = 3 + 14 + 6 + 20 + 48 + 7 + 19;
   localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

   logic         ADA_DCO;
   logic         i_reset;
   logic         i_enable;
   adc_code_t    i_adc_data;
   logic         i_adc_or;
   tank_sample_t o_sample;
   logic         o_sample_valid;
   logic         i_sample_ready;
   gate_vec_t    i_mosfet_cmd;
   dt_sel_t      i_deadtime_sel;
   gate_vec_t    o_gate;
   logic         o_shoot_through;

   logic [31:0]  lfsr_state;
   int           cycle_cnt;

   bridge_ctrl_top DUT (.*);

   // 4 ns clock
   always #2 ADA_DCO = ~ADA_DCO;

   // run limit
   always @(posedge ADA_DCO) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Simulation FAILED");
         $fatal(1);
      end
   end

   // ==================================================================
   // helpers
   // ==================================================================
   // step to 1 ns after the next rising edge
   task automatic tick();
      @(posedge ADA_DCO);
      #1;
   endtask

   task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                              input string msg);
      if (got !== exp) begin
         $display("[FAIL] t=%0t %s: got 0x%0h expected 0x%0h", $time, msg, got, exp);
         $display("Simulation FAILED");
         $fatal(1);
      end
   endtask

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
   endfunction

   // one LFSR step per bit taken
   task automatic draw_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
   endtask

   // negated code or the opposite full scale on over-range
   function automatic tank_sample_t expected_sample(input adc_code_t code, input logic orng);
      tank_sample_t s;
      s.clamped = orng;
      if (orng) begin
         s.value = (code == CODE_MIN) ? CODE_MAX : CODE_MIN;
      end else begin
         s.value = ~code + adc_code_t'(1);
      end
      return s;
   endfunction

   function automatic int dead_time_len(input dt_sel_t sel);
      case (sel)
         2'b00:   return `DEADTIME_SEL0;
         2'b10:   return `DEADTIME_SEL1;
         2'b01:   return `DEADTIME_SEL2;
         default: return `DEADTIME_SEL3;
      endcase
   endfunction

   task automatic check_gates(input gate_vec_t exp_gate, input logic exp_st, input string msg);
      check_equal(32'(o_gate), 32'(exp_gate), {msg, " gate"});
      check_equal(32'(o_shoot_through), 32'(exp_st), {msg, " shoot-through"});
   endtask

   task automatic send_sample(input adc_code_t code, input logic orng);
      i_adc_data = code;
      i_adc_or   = orng;
      tick();
      check_equal(32'(o_sample_valid), 32'd1, "sample valid");
      check_equal(32'(o_sample), 32'(expected_sample(code, orng)), "sample value");
   endtask

   // ==================================================================
   // directed tests
   // ==================================================================
   task automatic test_adc_convert();
      logic [31:0] v;
      i_sample_ready = 1'b1;
      // in-range codes are negated
      for (int i = 0; i < 8; i++) begin
         draw_bits(`ADC_WIDTH, v);
         send_sample(v[`ADC_WIDTH-1:0], 1'b0);
      end
      // over-range clamps
      send_sample(CODE_MIN, 1'b1);
      send_sample(CODE_MAX, 1'b1);
      send_sample('0, 1'b1);
      for (int i = 0; i < 3; i++) begin
         draw_bits(`ADC_WIDTH, v);
         send_sample(v[`ADC_WIDTH-1:0], 1'b1);
      end
   endtask

   task automatic test_back_pressure();
      logic [31:0]  v;
      adc_code_t    held;
      tank_sample_t held_exp;
      draw_bits(`ADC_WIDTH, v);
      held = v[`ADC_WIDTH-1:0];
      held_exp = expected_sample(held, 1'b0);
      send_sample(held, 1'b0);
      // stalled conversions are dropped
      i_sample_ready = 1'b0;
      for (int i = 0; i < 4; i++) begin
         draw_bits(`ADC_WIDTH + 1, v);
         i_adc_data = v[`ADC_WIDTH:1];
         i_adc_or   = v[0];
         tick();
         check_equal(32'(o_sample_valid), 32'd1, "stalled valid");
         check_equal(32'(o_sample), 32'(held_exp), "stalled sample");
      end
      i_sample_ready = 1'b1;
      draw_bits(`ADC_WIDTH, v);
      send_sample(v[`ADC_WIDTH-1:0], 1'b0);
   endtask

   task automatic test_startup();
      gate_vec_t exp;
      i_mosfet_cmd   = 4'b0011;
      i_deadtime_sel = 2'b00;
      i_enable       = 1'b1;
      // gate k edges after enable shows the count k-1
      for (int k = 1; k <= 20; k++) begin
         tick();
         if (k <= `STARTUP_ON_CYCLES + 1) begin
            exp = 4'b1100;
         end else if (k <= `STARTUP_VG_CYCLES + 1) begin
            exp = 4'b1001;
         end else begin
            exp = 4'b0011;
         end
         check_gates(exp, 1'b0, "start-up");
      end
   endtask

   task automatic test_dead_time();
      dt_sel_t   sel_list [4];
      gate_vec_t mask;
      int        d;
      sel_list = '{2'b00, 2'b10, 2'b01, 2'b11};
      for (int s = 0; s < 4; s++) begin
         i_mosfet_cmd = '0;
         tick();
         tick();
         check_gates('0, 1'b0, "dead time clear");
         // one switch per select code
         mask = gate_vec_t'(1 << s);
         d = dead_time_len(sel_list[s]);
         i_deadtime_sel = sel_list[s];
         i_mosfet_cmd   = mask;
         for (int k = 1; k <= d + 1; k++) begin
            tick();
            check_gates((k == d + 1) ? mask : '0, 1'b0, "dead time rise");
         end
         tick();
         tick();
         check_gates(mask, 1'b0, "dead time hold");
         i_mosfet_cmd = '0;
         tick();
         check_gates(mask, 1'b0, "dead time fall first edge");
         tick();
         check_gates('0, 1'b0, "dead time fall");
      end
   endtask

   task automatic test_shoot_through();
      int d;
      d = dead_time_len(2'b10);
      i_deadtime_sel = 2'b10;
      // M1 with M3 shorts leg 1
      i_mosfet_cmd = 4'b0101;
      for (int k = 1; k <= d + 1; k++) begin
         tick();
         check_gates('0, (k == d + 1), "guard rise");
      end
      tick();
      tick();
      check_gates('0, 1'b1, "guard hold");
      i_mosfet_cmd = '0;
      tick();
      check_gates('0, 1'b1, "guard release first edge");
      tick();
      check_gates('0, 1'b0, "guard release");
   endtask

   task automatic test_restart();
      i_mosfet_cmd   = 4'b0011;
      i_deadtime_sel = 2'b10;
      repeat (4) tick();
      check_gates(4'b0011, 1'b0, "run before disable");
      i_enable = 1'b0;
      tick();
      check_gates('0, 1'b0, "disable");
      tick();
      tick();
      check_gates('0, 1'b0, "disabled");
      // counter was cleared so bootstrap repeats
      i_enable = 1'b1;
      for (int k = 1; k <= `STARTUP_ON_CYCLES + 1; k++) begin
         tick();
         check_gates(4'b1100, 1'b0, "restart bootstrap");
      end
      tick();
      check_gates(4'b1001, 1'b0, "restart precharge");
   endtask

   // ==================================================================
   // main sequence
   // ==================================================================
   initial begin
      ADA_DCO        = 1'b0;
      i_reset        = 1'b1;
      i_enable       = 1'b0;
      i_adc_data     = '0;
      i_adc_or       = 1'b0;
      i_sample_ready = 1'b0;
      i_mosfet_cmd   = '0;
      i_deadtime_sel = '0;
      lfsr_state     = 32'ha640_fbf8;
      cycle_cnt      = 0;
      repeat (3) tick();
      check_gates('0, 1'b0, "after reset");
      check_equal(32'(o_sample_valid), 32'd0, "valid after reset");
      i_reset = 1'b0;
      test_adc_convert();
      test_back_pressure();
      test_startup();
      test_dead_time();
      test_shoot_through();
      test_restart();
      $display("Simulation PASSED");
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+include
hw/bridge_pkg.sv
hw/tank_adc_capture.sv
hw/startup_sequencer.sv
hw/dead_time_gen.sv
hw/gate_drive_logic.sv
hw/bridge_ctrl_top.sv
sim/tb_bridge_ctrl.sv

// ==== Makefile ====
# Verilator build and run of the bridge front end testbench

VERILATOR ?= verilator
TOP       ?= tb_bridge_ctrl
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
